//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_dcache_mem
FILELIST := filelist.f
LOG      := sim.log

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
+incdir+verilog
+incdir+test
verilog/dcache_geom_pkg.sv
verilog/dcache_req_pkg.sv
verilog/dcache_port_arb.sv
verilog/dcache_arrays.sv
verilog/dcache_hit_select.sv
verilog/dcache_mem_top.sv
test/tb_dcache_mem.sv

//--- test/tb_dcache_ref.svh
`ifndef TB_DCACHE_REF_SVH
`define TB_DCACHE_REF_SVH

typedef struct packed {
  way_vec_t vld;
  way_vec_t hit;
  logic     cap;
  line_t    data;
} rd_exp_t;

// model of the store, one entry per set and way
way_vec_t    m_vld  [(1 << `DC_IDX_W)] = '{default: '0};
tag_t        m_tag  [(1 << `DC_IDX_W)][`DC_WAYS];
logic        m_cap  [(1 << `DC_IDX_W)][`DC_WAYS];
line_t       m_data [(1 << `DC_IDX_W)][`DC_WAYS];
logic [31:0] lcg_state = 32'hdb1d;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

// expected result of a read, data and cap taken from the lowest hit
function automatic rd_exp_t ref_read(idx_t s, tag_t t);
  rd_exp_t e;
  e = '0;
  e.vld = m_vld[s];
  for (int w = `DC_WAYS - 1; w >= 0; w--) begin
    if (m_vld[s][w] && m_tag[s][w] == t) begin
      e.hit[w] = 1'b1;
      e.cap    = m_cap[s][w];
      e.data   = m_data[s][w];
    end
  end
  return e;
endfunction

task automatic model_write(idx_t s, way_vec_t ways, way_vec_t vld, tag_t t, logic c, line_t d);
  for (int w = 0; w < `DC_WAYS; w++) begin
    if (ways[w]) begin
      m_vld[s][w] = vld[w];
      m_tag[s][w] = t;
      m_cap[s][w] = c;
      if (vld[w]) m_data[s][w] = d; // invalidation leaves data alone
    end
  end
endtask

`endif

//--- test/tb_dcache_mem.sv
`timescale 1ns/1ns
`include "dcache_mem_defs.svh"

module tb_dcache_mem;
  import dcache_geom_pkg::*;
  import dcache_req_pkg::*;

  `include "tb_dcache_ref.svh"

  logic clk_i, rst_ni;
  port_vec_t rd_req, rd_prio, rd_ack, ack_q;
  idx_t [`DC_RD_PORTS-1:0] rd_idx;
  tag_t [`DC_RD_PORTS-1:0] rd_tag;
  way_vec_t rd_vld_bits, rd_hit_oh, wr_cl_we, wr_vld_bits, wr_req;
  line_t rd_data, wr_cl_data, wr_data;
  logic rd_cap_vld, wr_cl_vld, wr_cl_cap, wr_cap_tag, wr_ack;
  idx_t wr_cl_idx, wr_idx;
  tag_t wr_cl_tag, wr_tag;
  logic rd_pend = 1'b0;
  rd_exp_t pend_exp;
  port_idx_t rr_exp = '0; // expected round-robin pointer
  int errors = 0;

  dcache_mem_top i_dut (
    .clk_i, .rst_ni, .rd_req_i(rd_req), .rd_prio_i(rd_prio), .rd_idx_i(rd_idx),
    .rd_tag_i(rd_tag), .rd_ack_o(rd_ack), .rd_vld_bits_o(rd_vld_bits),
    .rd_hit_oh_o(rd_hit_oh), .rd_data_o(rd_data), .rd_cap_vld_o(rd_cap_vld),
    .wr_cl_vld_i(wr_cl_vld), .wr_cl_we_i(wr_cl_we), .wr_cl_idx_i(wr_cl_idx),
    .wr_cl_tag_i(wr_cl_tag), .wr_cl_data_i(wr_cl_data), .wr_cl_cap_i(wr_cl_cap),
    .wr_vld_bits_i(wr_vld_bits), .wr_req_i(wr_req), .wr_idx_i(wr_idx), .wr_tag_i(wr_tag),
    .wr_data_i(wr_data), .wr_cap_tag_i(wr_cap_tag), .wr_ack_o(wr_ack)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_run(string line);
    errors++;
    $display("%s", line);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic mismatch(string what);
    stop_run($sformatf("Mismatch at %0t ns: %s", $time, what));
  endtask

  ////////////////////////////////////////////////////////////
  // comparison against the model on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare
    port_vec_t masked;
    port_vec_t exp_ack;
    port_idx_t sel;
    if (rst_ni) begin
      if (rd_pend) begin
        assert (rd_vld_bits == pend_exp.vld && rd_hit_oh == pend_exp.hit)
          else mismatch($sformatf("vld %h hit %h, expected %h %h", rd_vld_bits, rd_hit_oh,
                                  pend_exp.vld, pend_exp.hit));
        if (|pend_exp.hit) begin
          assert (rd_data == pend_exp.data && rd_cap_vld == pend_exp.cap)
            else mismatch("read data or capability bit differs from model");
        end
      end
      assert (wr_ack == ((|wr_req) && !wr_cl_vld)) else mismatch("wrong write acknowledge");
      masked  = (|(rd_req & rd_prio)) ? (rd_req & rd_prio) : rd_req;
      sel     = masked[rr_exp] ? rr_exp : ~rr_exp;
      exp_ack = (wr_cl_vld || (|wr_req) || masked == '0) ? '0 : port_vec_t'(1 << sel);
      assert (rd_ack == exp_ack)
        else mismatch($sformatf("read ack %b, expected %b", rd_ack, exp_ack));
      rd_pend = |exp_ack;
      if (rd_pend) begin
        pend_exp = ref_read(rd_idx[sel], rd_tag[sel]);
        rr_exp   = ~sel;
      end
      if (wr_cl_vld) begin
        model_write(wr_cl_idx, wr_cl_we, wr_vld_bits, wr_cl_tag, wr_cl_cap, wr_cl_data);
      end else if (wr_ack) begin
        model_write(wr_idx, wr_req, wr_req, wr_tag, wr_cap_tag, wr_data);
      end
      ack_q = rd_ack;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic refill(idx_t s, way_vec_t ways, way_vec_t vld, tag_t t, line_t d, logic c);
    @(posedge clk_i);
    wr_cl_vld   <= 1'b1;
    wr_cl_we    <= ways;
    wr_vld_bits <= vld;
    wr_cl_idx   <= s;
    wr_cl_tag   <= t;
    wr_cl_data  <= d;
    wr_cl_cap   <= c;
    @(posedge clk_i);
    wr_cl_vld <= 1'b0;
  endtask

  task automatic word_write(idx_t s, way_vec_t way, tag_t t, line_t d, logic c);
    @(posedge clk_i);
    wr_req     <= way;
    wr_idx     <= s;
    wr_tag     <= t;
    wr_data    <= d;
    wr_cap_tag <= c;
    @(posedge clk_i);
    wr_req <= '0; // taken in the first cycle since no refill competes
  endtask

  // both selected ports read the same set and tag until each is acked
  task automatic read(port_vec_t ports, port_vec_t prio, idx_t s, tag_t t);
    port_vec_t left;
    int n;
    left = ports;
    n = 0;
    @(posedge clk_i);
    rd_req  <= ports;
    rd_prio <= prio;
    rd_idx  <= {s, s};
    rd_tag  <= {t, t};
    while (left != '0) begin
      @(posedge clk_i);
      left = left & ~ack_q;
      rd_req <= left;
      n++;
      if (n > 20) stop_run("timeout waiting for read acknowledge");
    end
  endtask

  initial begin
    logic [31:0] r, r2;
    rst_ni      = 1'b0;
    rd_req      = '0;
    rd_prio     = '0;
    rd_idx      = '0;
    rd_tag      = '0;
    ack_q       = '0;
    wr_cl_vld   = 1'b0;
    wr_cl_we    = '0;
    wr_cl_idx   = '0;
    wr_cl_tag   = '0;
    wr_cl_data  = '0;
    wr_cl_cap   = 1'b0;
    wr_vld_bits = '0;
    wr_req      = '0;
    wr_idx      = '0;
    wr_tag      = '0;
    wr_data     = '0;
    wr_cap_tag  = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    read(2'b01, 2'b00, 4'd3, 8'h05);  // empty store misses
    read(2'b10, 2'b00, 4'd0, 8'h00);
    refill(4'd2, 4'b0010, 4'b0010, 8'h21, {4{32'hcafe0001}}, 1'b1);
    read(2'b01, 2'b00, 4'd2, 8'h21);
    read(2'b10, 2'b00, 4'd2, 8'h25);
    word_write(4'd2, 4'b0010, 8'h21, {4{32'h5eed0002}}, 1'b0);
    read(2'b01, 2'b00, 4'd2, 8'h21);
    refill(4'd2, 4'b0010, 4'b0000, 8'h21, '0, 1'b0); // invalidate way 1
    read(2'b10, 2'b00, 4'd2, 8'h21); // leaves the pointer on port 0
    // refill, word write and both reads at once with port 1 high priority
    @(posedge clk_i);
    wr_cl_vld   <= 1'b1;
    wr_cl_we    <= 4'b0001;
    wr_vld_bits <= 4'b0001;
    wr_cl_idx   <= 4'd5;
    wr_cl_tag   <= 8'h10;
    wr_req      <= 4'b0100;
    wr_idx      <= 4'd5;
    wr_tag      <= 8'h0e;
    rd_req      <= 2'b11;
    rd_prio     <= 2'b10;
    rd_idx      <= {4'd5, 4'd5};
    rd_tag      <= {8'h0e, 8'h0e};
    @(posedge clk_i);
    wr_cl_vld <= 1'b0;
    @(posedge clk_i);
    wr_req <= '0;
    read(2'b11, 2'b10, 4'd5, 8'h0e);
    // random mix of refills, word writes and reads
    // the low tag bits carry the way number so tags stay unique per set
    for (int c = 0; c < 300; c++) begin
      @(posedge clk_i);
      r  = lcg_next();
      r2 = lcg_next();
      wr_cl_vld   <= (r[2:0] == 3'd0);
      wr_cl_we    <= way_vec_t'(1 << r[4:3]);
      wr_cl_idx   <= idx_t'(r[6:5]);
      wr_cl_tag   <= {4'b0, r[8:7], r[4:3]};
      wr_vld_bits <= {4{r[9] | r[10]}};
      wr_cl_data  <= {4{lcg_next()}};
      wr_cl_cap   <= r[11];
      wr_req      <= (r[14:12] == 3'd0) ? way_vec_t'(1 << r[16:15]) : '0;
      wr_idx      <= idx_t'(r[18:17]);
      wr_tag      <= {4'b0, r[20:19], r[16:15]};
      wr_data     <= {4{lcg_next()}};
      wr_cap_tag  <= r[21];
      rd_prio     <= r2[1:0];
      for (int p = 0; p < `DC_RD_PORTS; p++) begin
        if (ack_q[p]) rd_req[p] <= 1'b0; // tag held for the compare cycle
        else if (!rd_req[p] && r2[2+p]) begin
          rd_req[p] <= 1'b1;
          rd_idx[p] <= idx_t'(r2[5+4*p +: 2]);
          rd_tag[p] <= {4'b0, r2[7+4*p +: 2], r2[20+2*p +: 2]};
        end
      end
    end
    repeat (3) @(posedge clk_i);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

//--- verilog/dcache_arrays.sv
`timescale 1ns/1ns
`include "dcache_mem_defs.svh"

module dcache_arrays (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  dcache_geom_pkg::way_vec_t                  req_i,
  input  logic                                       we_i,
  input  dcache_geom_pkg::way_vec_t                  data_we_i,
  input  dcache_geom_pkg::idx_t                      idx_i,
  input  dcache_geom_pkg::way_vec_t                  vld_i,
  input  dcache_geom_pkg::tag_t                      tag_i,
  input  logic                                       cap_i,
  input  dcache_geom_pkg::line_t                     data_i,
  output dcache_geom_pkg::way_vec_t                  vld_o,
  output dcache_geom_pkg::tag_t [`DC_WAYS-1:0]       tag_o,
  output dcache_geom_pkg::way_vec_t                  cap_o,
  output dcache_geom_pkg::line_t [`DC_WAYS-1:0]      data_o
);

  import dcache_geom_pkg::*;

  localparam int unsigned NumSets = 1 << `DC_IDX_W;

  way_vec_t vld_mem  [NumSets-1:0];
  way_vec_t cap_mem  [NumSets-1:0];
  tag_t     tag_mem  [NumSets-1:0][`DC_WAYS-1:0];
  line_t    data_mem [NumSets-1:0][`DC_WAYS-1:0];

  logic rd_en;

  assign rd_en = (|req_i) & ~we_i;

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NumSets; s++) begin
        vld_mem[s] <= '0;
      end
      vld_o <= '0;
    end else begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (req_i[w] && we_i) vld_mem[idx_i][w] <= vld_i[w];
      end
      if (rd_en) vld_o <= vld_mem[idx_i]; // seen by the compare stage next cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // tag, capability bit and data storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (req_i[w] && we_i) begin
        tag_mem[idx_i][w] <= tag_i;
        cap_mem[idx_i][w] <= cap_i;
        if (data_we_i[w]) data_mem[idx_i][w] <= data_i;
      end
      // read side, every way of the set
      if (req_i[w] && !we_i) begin
        tag_o[w]  <= tag_mem[idx_i][w];
        cap_o[w]  <= cap_mem[idx_i][w];
        data_o[w] <= data_mem[idx_i][w];
      end
    end
  end

endmodule

//--- verilog/dcache_geom_pkg.sv
`include "dcache_mem_defs.svh"

package dcache_geom_pkg;

  ////////////////////////////////////////////////////////////
  // storage geometry
  ////////////////////////////////////////////////////////////

  // address tag as stored per way
  typedef logic [`DC_TAG_W-1:0] tag_t;

  typedef logic [`DC_IDX_W-1:0] idx_t; // set index

  // a line is one capability word, the tag bit lives apart
  typedef logic [`DC_LINE_W-1:0] line_t;

  // one bit per way
  typedef logic [`DC_WAYS-1:0] way_vec_t;

  // binary way number
  typedef logic [$clog2(`DC_WAYS)-1:0] way_idx_t;

endpackage

//--- verilog/dcache_hit_select.sv
`timescale 1ns/1ns
`include "dcache_mem_defs.svh"

module dcache_hit_select (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       rd_acked_i,
  input  dcache_req_pkg::port_idx_t                  rd_sel_i,
  input  dcache_geom_pkg::tag_t [`DC_RD_PORTS-1:0]   rd_tag_i,  // arrives one cycle after ack
  input  dcache_geom_pkg::way_vec_t                  vld_i,
  input  dcache_geom_pkg::tag_t [`DC_WAYS-1:0]       tag_i,
  input  dcache_geom_pkg::way_vec_t                  cap_i,
  input  dcache_geom_pkg::line_t [`DC_WAYS-1:0]      data_i,
  output dcache_geom_pkg::way_vec_t                  rd_vld_bits_o,
  output dcache_geom_pkg::way_vec_t                  rd_hit_oh_o,
  output dcache_geom_pkg::line_t                     rd_data_o,
  output logic                                       rd_cap_vld_o
);

  import dcache_geom_pkg::*;
  import dcache_req_pkg::*;

  logic      cmp_en_q;
  port_idx_t rd_sel_q;
  tag_t      rd_tag;
  way_idx_t  hit_idx;

  ////////////////////////////////////////////////////////////
  // read context
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmp_en_q <= 1'b0;
      rd_sel_q <= '0;
    end else begin
      cmp_en_q <= rd_acked_i;
      rd_sel_q <= rd_sel_i;
    end
  end

  assign rd_tag = rd_tag_i[rd_sel_q]; // late tag of the acked port

  ////////////////////////////////////////////////////////////
  // tag compare and output muxes
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      rd_hit_oh_o[w] = cmp_en_q & vld_i[w] & (tag_i[w] == rd_tag);
    end
  end

  // lowest hit wins, way 0 on a miss
  always_comb begin
    hit_idx = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (rd_hit_oh_o[w]) hit_idx = way_idx_t'(w);
    end
  end

  assign rd_vld_bits_o = vld_i;
  assign rd_data_o     = data_i[hit_idx];
  assign rd_cap_vld_o  = cap_i[hit_idx];

  // a tag may sit in at most one valid way of a set
  hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rd_acked_i |=> $onehot0(rd_hit_oh_o))
    else $error("read hit vector must be one-hot or zero");

endmodule

//--- verilog/dcache_mem_defs.svh
`ifndef DCACHE_MEM_DEFS_SVH
`define DCACHE_MEM_DEFS_SVH

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////

// number of ways per set
`define DC_WAYS 4

// set index width, 16 sets
`define DC_IDX_W 4

// address tag width
`define DC_TAG_W 8

// one line holds exactly one capability word
`define DC_LINE_W 128

////////////////////////////////////////////////////////////
// request side
////////////////////////////////////////////////////////////

`define DC_RD_PORTS 2 // read ports competing for the store

`endif

//--- verilog/dcache_mem_top.sv
`timescale 1ns/1ns
`include "dcache_mem_defs.svh"

module dcache_mem_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // read ports
  input  dcache_req_pkg::port_vec_t                  rd_req_i,
  input  dcache_req_pkg::port_vec_t                  rd_prio_i,
  input  dcache_geom_pkg::idx_t [`DC_RD_PORTS-1:0]   rd_idx_i,
  input  dcache_geom_pkg::tag_t [`DC_RD_PORTS-1:0]   rd_tag_i,
  output dcache_req_pkg::port_vec_t                  rd_ack_o,
  output dcache_geom_pkg::way_vec_t                  rd_vld_bits_o,
  output dcache_geom_pkg::way_vec_t                  rd_hit_oh_o,
  output dcache_geom_pkg::line_t                     rd_data_o,
  output logic                                       rd_cap_vld_o,
  // refill, always accepted
  input  logic                                       wr_cl_vld_i,
  input  dcache_geom_pkg::way_vec_t                  wr_cl_we_i,
  input  dcache_geom_pkg::idx_t                      wr_cl_idx_i,
  input  dcache_geom_pkg::tag_t                      wr_cl_tag_i,
  input  dcache_geom_pkg::line_t                     wr_cl_data_i,
  input  logic                                       wr_cl_cap_i,
  input  dcache_geom_pkg::way_vec_t                  wr_vld_bits_i,
  // single word write
  input  dcache_geom_pkg::way_vec_t                  wr_req_i,
  input  dcache_geom_pkg::idx_t                      wr_idx_i,
  input  dcache_geom_pkg::tag_t                      wr_tag_i,
  input  dcache_geom_pkg::line_t                     wr_data_i,
  input  logic                                       wr_cap_tag_i,
  output logic                                       wr_ack_o
);

  import dcache_geom_pkg::*;
  import dcache_req_pkg::*;

  way_vec_t                arr_req;
  logic                    arr_we;
  way_vec_t                arr_data_we;
  idx_t                    arr_idx;
  way_vec_t                arr_vld;
  tag_t                    arr_tag;
  logic                    arr_cap;
  line_t                   arr_data;
  logic                    rd_acked;
  port_idx_t               rd_sel;

  way_vec_t                way_vld;
  tag_t  [`DC_WAYS-1:0]    way_tag;
  way_vec_t                way_cap;
  line_t [`DC_WAYS-1:0]    way_data;

  assign arr_data = wr_cl_vld_i ? wr_cl_data_i : wr_data_i; // refill data has priority

  dcache_port_arb i_port_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_idx_i      (rd_idx_i),
    .rd_ack_o      (rd_ack_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_cl_cap_i   (wr_cl_cap_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_req_i      (wr_req_i),
    .wr_idx_i      (wr_idx_i),
    .wr_tag_i      (wr_tag_i),
    .wr_cap_tag_i  (wr_cap_tag_i),
    .wr_ack_o      (wr_ack_o),
    .arr_req_o     (arr_req),
    .arr_we_o      (arr_we),
    .arr_data_we_o (arr_data_we),
    .arr_idx_o     (arr_idx),
    .arr_vld_o     (arr_vld),
    .arr_tag_o     (arr_tag),
    .arr_cap_o     (arr_cap),
    .rd_acked_o    (rd_acked),
    .rd_sel_o      (rd_sel)
  );

  dcache_arrays i_arrays (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (arr_req),
    .we_i      (arr_we),
    .data_we_i (arr_data_we),
    .idx_i     (arr_idx),
    .vld_i     (arr_vld),
    .tag_i     (arr_tag),
    .cap_i     (arr_cap),
    .data_i    (arr_data),
    .vld_o     (way_vld),
    .tag_o     (way_tag),
    .cap_o     (way_cap),
    .data_o    (way_data)
  );

  dcache_hit_select i_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_acked_i    (rd_acked),
    .rd_sel_i      (rd_sel),
    .rd_tag_i      (rd_tag_i),
    .vld_i         (way_vld),
    .tag_i         (way_tag),
    .cap_i         (way_cap),
    .data_i        (way_data),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o),
    .rd_cap_vld_o  (rd_cap_vld_o)
  );

endmodule

//--- verilog/dcache_port_arb.sv
`timescale 1ns/1ns
`include "dcache_mem_defs.svh"

module dcache_port_arb (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // read ports
  input  dcache_req_pkg::port_vec_t                     rd_req_i,
  input  dcache_req_pkg::port_vec_t                     rd_prio_i,
  input  dcache_geom_pkg::idx_t [`DC_RD_PORTS-1:0]      rd_idx_i,
  output dcache_req_pkg::port_vec_t                     rd_ack_o,
  // refill
  input  logic                                          wr_cl_vld_i,
  input  dcache_geom_pkg::way_vec_t                     wr_cl_we_i,
  input  dcache_geom_pkg::idx_t                         wr_cl_idx_i,
  input  dcache_geom_pkg::tag_t                         wr_cl_tag_i,
  input  logic                                          wr_cl_cap_i,
  input  dcache_geom_pkg::way_vec_t                     wr_vld_bits_i,
  // word write
  input  dcache_geom_pkg::way_vec_t                     wr_req_i,
  input  dcache_geom_pkg::idx_t                         wr_idx_i,
  input  dcache_geom_pkg::tag_t                         wr_tag_i,
  input  logic                                          wr_cap_tag_i,
  output logic                                          wr_ack_o,
  // array controls
  output dcache_geom_pkg::way_vec_t                     arr_req_o,
  output logic                                          arr_we_o,
  output dcache_geom_pkg::way_vec_t                     arr_data_we_o,
  output dcache_geom_pkg::idx_t                         arr_idx_o,
  output dcache_geom_pkg::way_vec_t                     arr_vld_o,
  output dcache_geom_pkg::tag_t                         arr_tag_o,
  output logic                                          arr_cap_o,
  // read context for the compare stage
  output logic                                          rd_acked_o,
  output dcache_req_pkg::port_idx_t                     rd_sel_o
);

  import dcache_req_pkg::*;

  mem_op_e   op;
  port_vec_t rd_req_prio;   // high prio requests only
  port_vec_t rd_req_masked; // requests left after masking
  port_idx_t rr_q;          // port favoured on the next tie
  port_idx_t rd_sel;

  ////////////////////////////////////////////////////////////
  // operation select
  ////////////////////////////////////////////////////////////

  // refill beats word write, word write beats any read
  always_comb begin
    if (wr_cl_vld_i)      op = OP_REFILL;
    else if (|wr_req_i)   op = OP_WORD_WR;
    else if (|rd_req_i)   op = OP_READ;
    else                  op = OP_IDLE;
  end

  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // round robin search starting at the pointer
  always_comb begin : p_rr_pick
    int   p;
    logic found;
    rd_sel = rr_q;
    found  = 1'b0;
    for (int i = 0; i < `DC_RD_PORTS; i++) begin
      p = (int'(rr_q) + i) % `DC_RD_PORTS;
      if (!found && rd_req_masked[p]) begin
        rd_sel = port_idx_t'(p);
        found  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (op == OP_READ) begin
      rr_q <= (int'(rd_sel) == `DC_RD_PORTS - 1) ? '0 : rd_sel + 1'b1; // move past the winner
    end
  end

  ////////////////////////////////////////////////////////////
  // acknowledges and array controls
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_ack_o = '0;
    if (op == OP_READ) rd_ack_o[rd_sel] = 1'b1;
  end

  assign wr_ack_o   = (op == OP_WORD_WR);
  assign rd_acked_o = (op == OP_READ);
  assign rd_sel_o   = rd_sel;

  always_comb begin
    arr_req_o     = '0;
    arr_we_o      = 1'b0;
    arr_data_we_o = '0;
    arr_idx_o     = rd_idx_i[rd_sel];
    arr_vld_o     = '0;
    arr_tag_o     = '0;
    arr_cap_o     = 1'b0;
    case (op)
      OP_REFILL: begin
        arr_req_o     = wr_cl_we_i;
        arr_we_o      = 1'b1;
        arr_data_we_o = wr_cl_we_i & wr_vld_bits_i; // no data needed when invalidating
        arr_idx_o     = wr_cl_idx_i;
        arr_vld_o     = wr_vld_bits_i;
        arr_tag_o     = wr_cl_tag_i;
        arr_cap_o     = wr_cl_cap_i;
      end
      OP_WORD_WR: begin
        arr_req_o     = wr_req_i;
        arr_we_o      = 1'b1;
        arr_data_we_o = wr_req_i;
        arr_idx_o     = wr_idx_i;
        arr_vld_o     = wr_req_i; // written way stays valid
        arr_tag_o     = wr_tag_i;
        arr_cap_o     = wr_cap_tag_i;
      end
      OP_READ: begin
        arr_req_o = '1; // all ways of the set
      end
      default: ;
    endcase
  end

  word_wr_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_ack_o |-> $onehot0(wr_req_i))
    else $error("word write must target at most one way");

endmodule

//--- verilog/dcache_req_pkg.sv
`include "dcache_mem_defs.svh"

package dcache_req_pkg;

  typedef logic [`DC_RD_PORTS-1:0] port_vec_t; // one bit per read port

  // read port number
  typedef logic [$clog2(`DC_RD_PORTS)-1:0] port_idx_t;

  // array operation picked by the arbiter each cycle
  typedef enum logic [1:0] {
    OP_IDLE    = 2'd0,
    OP_REFILL  = 2'd1,
    OP_WORD_WR = 2'd2,
    OP_READ    = 2'd3
  } mem_op_e;

endpackage
